/* verilog/regstate_cfg.svh */
`ifndef REGSTATE_CFG_SVH
`define REGSTATE_CFG_SVH

// Datapath and register file geometry
`define REGSTATE_XLEN   32
`define REGSTATE_NREGS  32
`define REGSTATE_IDXW   5
`define REGSTATE_IRQS   16
`define REGSTATE_FLAGW  4

// GPR indices with special meaning
// r31 is shadowed by the kernel stack pointer in kernel mode
`define REGSTATE_ALIAS_REG  31
// Compiler places the return value in r1
`define REGSTATE_RET_REG    1

// Control register indices
`define CR_PSR   0
`define CR_PID   1
`define CR_ISR   2
`define CR_IMR   3
`define CR_EPC   4
`define CR_FLG   5
`define CR_EFG   6
`define CR_TLBA  7
`define CR_CID   9

// Global interrupt enable inside IMR
`define IMR_EN_BIT  31

`endif

/* verilog/regstate_pkg.sv */
`include "regstate_cfg.svh"

package regstate_pkg;

  typedef logic [`REGSTATE_XLEN-1:0] word_t;
  typedef logic [`REGSTATE_IDXW-1:0] reg_idx_t;

  // Read addresses for both register files
  typedef struct packed {
    reg_idx_t raddr0;
    reg_idx_t raddr1;
    logic     read_no_alias;  // crmv style access, r31 is never the KSP
    reg_idx_t craddr;
  } rd_req_t;

  // One writeback port as delivered by the pipeline
  typedef struct packed {
    logic     wen;
    reg_idx_t waddr;
    word_t    wdata;
    logic     no_alias;
  } wb_port_t;

  typedef struct packed {
    wb_port_t port0;
    wb_port_t port1;  // Post-increment address updates
    logic     cwen;
    reg_idx_t cwaddr;
    word_t    cwdata;
  } wb_req_t;

  // Exception and return events from the writeback stage
  typedef struct packed {
    logic                       exc;
    logic                       tlb_exc;
    logic                       irq;
    logic                       rfe;
    logic                       rfi;
    word_t                      epc;
    word_t                      efg;
    word_t                      tlb_addr;
    logic [`REGSTATE_FLAGW-1:0] flags_live;
  } exc_evt_t;

  // Resolved GPR write, aliasing and r0 filtering already applied
  typedef struct packed {
    logic     en;
    logic     to_ksp;
    reg_idx_t waddr;
    word_t    wdata;
  } gpr_cmd_t;

  typedef struct packed {
    logic force_zero;
    logic from_ksp;
  } gpr_rd_sel_t;

  typedef enum logic [1:0] {
    CR_OP_NONE      = 2'd0,
    CR_OP_EXC_ENTRY = 2'd1,
    CR_OP_RFE       = 2'd2
  } cr_op_e;

  typedef struct packed {
    cr_op_e   op;
    logic     tlb_capture;
    logic     irq_disable;
    logic     irq_enable;
    word_t    epc;
    word_t    efg;
    word_t    tlb_addr;
    logic     wen_plain;  // Any writable control register except ISR
    logic     wen_isr;
    reg_idx_t waddr;
    word_t    wdata;
  } cr_cmd_t;

  typedef struct packed {
    word_t rdata0;
    word_t rdata1;
    word_t crdata;
  } rd_data_t;

  typedef struct packed {
    logic  kmode;
    word_t interrupt_state;
    word_t pid;
    word_t epc_out;
    word_t efg_out;
    word_t ret_val;
  } status_t;

endpackage

/* verilog/wb_exc_ctrl.sv */
`include "regstate_cfg.svh"

module wb_exc_ctrl (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     clk_en,
  input  logic                     stall,
  input  regstate_pkg::rd_req_t    rd,
  input  regstate_pkg::wb_req_t    wb,
  input  regstate_pkg::exc_evt_t   evt,
  input  logic                     kmode,
  output regstate_pkg::gpr_cmd_t   gpr_wr0,
  output regstate_pkg::gpr_cmd_t   gpr_wr1,
  output regstate_pkg::gpr_rd_sel_t gpr_rd0_sel,
  output regstate_pkg::gpr_rd_sel_t gpr_rd1_sel,
  output regstate_pkg::cr_cmd_t    cr_cmd
);

  // Events may only retire on enabled, unstalled edges
  logic                  go;
  regstate_pkg::cr_cmd_t live_evt;
  regstate_pkg::cr_cmd_t held_q;
  regstate_pkg::cr_cmd_t evt_sel;

  // r31 maps to the KSP in kernel mode unless the access opts out
  function automatic logic is_ksp(input regstate_pkg::reg_idx_t idx,
                                  input logic no_alias, input logic km);
    return km && !no_alias && (idx == `REGSTATE_IDXW'(`REGSTATE_ALIAS_REG));
  endfunction

  // Writes to r0 vanish here so storage never sees them
  function automatic regstate_pkg::gpr_cmd_t resolve_wr(input regstate_pkg::wb_port_t p,
                                                        input logic en, input logic km);
    regstate_pkg::gpr_cmd_t c;
    c.en     = en && p.wen && (p.waddr != '0);
    c.to_ksp = is_ksp(p.waddr, p.no_alias, km);
    c.waddr  = p.waddr;
    c.wdata  = p.wdata;
    return c;
  endfunction

  function automatic regstate_pkg::gpr_rd_sel_t resolve_rd(input regstate_pkg::reg_idx_t a,
                                                           input logic no_alias,
                                                           input logic km);
    regstate_pkg::gpr_rd_sel_t s;
    s.force_zero = (a == '0);
    s.from_ksp   = is_ksp(a, no_alias, km);
    return s;
  endfunction

  assign go = clk_en && !stall;

  // Writes ignore stall and only wait for an enabled edge
  assign gpr_wr0 = resolve_wr(wb.port0, clk_en, kmode);
  assign gpr_wr1 = resolve_wr(wb.port1, clk_en, kmode);

  // Both read ports share the single no_alias flag
  assign gpr_rd0_sel = resolve_rd(rd.raddr0, rd.read_no_alias, kmode);
  assign gpr_rd1_sel = resolve_rd(rd.raddr1, rd.read_no_alias, kmode);

  // Exception beats return when both are flagged
  always_comb begin
    live_evt = '0;
    if (evt.exc) begin
      live_evt.op          = regstate_pkg::CR_OP_EXC_ENTRY;
      live_evt.tlb_capture = evt.tlb_exc;
      live_evt.irq_disable = evt.irq;
    end else if (evt.rfe) begin
      live_evt.op          = regstate_pkg::CR_OP_RFE;
      live_evt.irq_enable  = evt.rfi;
    end
    live_evt.epc      = evt.epc;
    live_evt.efg      = evt.efg;
    live_evt.tlb_addr = evt.tlb_addr;
  end

  // An event seen on a blocked cycle is parked until the next go edge
  // If the pipeline keeps presenting it, the parked copy is the same event
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      held_q <= '0;
    end else if (go) begin
      held_q.op <= regstate_pkg::CR_OP_NONE;
    end else if (held_q.op == regstate_pkg::CR_OP_NONE &&
                 live_evt.op != regstate_pkg::CR_OP_NONE) begin
      held_q <= live_evt;
    end
  end

  // Parked event has precedence, live one retires with it
  assign evt_sel = (held_q.op != regstate_pkg::CR_OP_NONE) ? held_q : live_evt;

  always_comb begin
    cr_cmd          = evt_sel;
    cr_cmd.op       = go ? evt_sel.op : regstate_pkg::CR_OP_NONE;
    cr_cmd.tlb_capture = go && evt_sel.tlb_capture;
    cr_cmd.irq_disable = go && evt_sel.irq_disable;
    cr_cmd.irq_enable  = go && evt_sel.irq_enable;
    // CID is read only, ISR has its own merge path
    cr_cmd.wen_plain = clk_en && wb.cwen &&
                       (wb.cwaddr != `REGSTATE_IDXW'(`CR_ISR)) &&
                       (wb.cwaddr != `REGSTATE_IDXW'(`CR_CID));
    cr_cmd.wen_isr   = clk_en && wb.cwen && (wb.cwaddr == `REGSTATE_IDXW'(`CR_ISR));
    cr_cmd.waddr     = wb.cwaddr;
    cr_cmd.wdata     = wb.cwdata;
  end

endmodule

/* verilog/gpr_file.sv */
`include "regstate_cfg.svh"

module gpr_file (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      clk_en,
  input  logic                      stall,
  input  regstate_pkg::gpr_cmd_t    gpr_wr0,
  input  regstate_pkg::gpr_cmd_t    gpr_wr1,
  input  regstate_pkg::reg_idx_t    raddr0,
  input  regstate_pkg::reg_idx_t    raddr1,
  input  regstate_pkg::gpr_rd_sel_t gpr_rd0_sel,
  input  regstate_pkg::gpr_rd_sel_t gpr_rd1_sel,
  output regstate_pkg::word_t       rdata0,
  output regstate_pkg::word_t       rdata1,
  output regstate_pkg::word_t       ret_val
);

  // r0 has no storage, it is hardwired to zero on read
  regstate_pkg::word_t regs [1:`REGSTATE_NREGS-1];
  regstate_pkg::word_t ksp;
  regstate_pkg::word_t rdata0_q;
  regstate_pkg::word_t rdata1_q;
  logic                rd_adv;

  // Read latches follow the decode stage
  assign rd_adv = clk_en && !stall;

  // Storage and KSP
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `REGSTATE_NREGS; i++) begin
        regs[i] <= '0;
      end
      ksp <= '0;
    end else begin
      // Port 0 first
      if (gpr_wr0.en) begin
        if (gpr_wr0.to_ksp) begin
          ksp <= gpr_wr0.wdata;
        end else begin
          regs[gpr_wr0.waddr] <= gpr_wr0.wdata;
        end
      end
      // Port 1 last so the address update survives a collision
      if (gpr_wr1.en) begin
        if (gpr_wr1.to_ksp) begin
          ksp <= gpr_wr1.wdata;
        end else begin
          regs[gpr_wr1.waddr] <= gpr_wr1.wdata;
        end
      end
    end
  end

  // Registered read port 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata0_q <= '0;
    end else if (rd_adv) begin
      if (gpr_rd0_sel.force_zero) begin
        rdata0_q <= '0;
      end else if (gpr_rd0_sel.from_ksp) begin
        rdata0_q <= ksp;
      end else begin
        rdata0_q <= regs[raddr0];
      end
    end
  end

  // Registered read port 1
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata1_q <= '0;
    end else if (rd_adv) begin
      if (gpr_rd1_sel.force_zero) begin
        rdata1_q <= '0;
      end else if (gpr_rd1_sel.from_ksp) begin
        rdata1_q <= ksp;
      end else begin
        rdata1_q <= regs[raddr1];
      end
    end
  end

  assign rdata0 = rdata0_q;
  assign rdata1 = rdata1_q;

  // Return value is exposed for test and debug
  assign ret_val = regs[`REGSTATE_RET_REG];

endmodule

/* verilog/ctrl_reg_file.sv */
`include "regstate_cfg.svh"

module ctrl_reg_file (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       clk_en,
  input  logic                       stall,
  input  regstate_pkg::cr_cmd_t      cr_cmd,
  input  regstate_pkg::reg_idx_t     craddr,
  input  logic [`REGSTATE_FLAGW-1:0] flags_live,
  input  logic [`REGSTATE_IRQS-1:0]  interrupts,
  output regstate_pkg::word_t        crdata,
  output regstate_pkg::status_t      status
);

  // Control register array, indexed by the CR_* numbers
  regstate_pkg::word_t cr_q [0:`REGSTATE_NREGS-1];
  regstate_pkg::word_t crdata_q;
  regstate_pkg::word_t flags_word;
  regstate_pkg::word_t irq_word;
  regstate_pkg::word_t crdata_d;
  regstate_pkg::word_t isr;
  regstate_pkg::word_t imr;
  logic                rd_adv;

  assign rd_adv     = clk_en && !stall;
  assign flags_word = `REGSTATE_XLEN'(flags_live);
  assign irq_word   = `REGSTATE_XLEN'(interrupts);
  assign isr        = cr_q[`CR_ISR];
  assign imr        = cr_q[`CR_IMR];

  // Read mux
  // cr0 and cr9 read as zero, cr5 shows the ALU flags as they are now
  always_comb begin
    case (craddr)
      `REGSTATE_IDXW'(`CR_PSR): crdata_d = '0;
      `REGSTATE_IDXW'(`CR_CID): crdata_d = '0;
      `REGSTATE_IDXW'(`CR_FLG): crdata_d = flags_word;
      default:                  crdata_d = cr_q[craddr];
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `REGSTATE_NREGS; i++) begin
        cr_q[i] <= '0;
      end
      // Come out of reset in kernel mode, nesting level 1
      cr_q[`CR_PSR] <= `REGSTATE_XLEN'(1);
    end else begin
      // Plain software writes, already gated on clk_en
      if (cr_cmd.wen_plain) begin
        cr_q[cr_cmd.waddr] <= cr_cmd.wdata;
      end

      // Event updates come after so they win over a plain write
      case (cr_cmd.op)
        regstate_pkg::CR_OP_EXC_ENTRY: begin
          cr_q[`CR_PSR] <= cr_q[`CR_PSR] + `REGSTATE_XLEN'(1);
          cr_q[`CR_EPC] <= cr_cmd.epc;
          cr_q[`CR_EFG] <= cr_cmd.efg;
          if (cr_cmd.tlb_capture) begin
            cr_q[`CR_TLBA] <= cr_cmd.tlb_addr;
          end
          // Interrupt entry masks further interrupts
          if (cr_cmd.irq_disable) begin
            cr_q[`CR_IMR][`IMR_EN_BIT] <= 1'b0;
          end
        end
        regstate_pkg::CR_OP_RFE: begin
          cr_q[`CR_PSR] <= cr_q[`CR_PSR] - `REGSTATE_XLEN'(1);
          // rfi reopens the interrupt gate
          if (cr_cmd.irq_enable) begin
            cr_q[`CR_IMR][`IMR_EN_BIT] <= 1'b1;
          end
        end
        default: begin
        end
      endcase

      // ISR is sticky and samples the lines on every clock
      // A software write replaces the pending bits but still merges new lines
      if (cr_cmd.wen_isr) begin
        cr_q[`CR_ISR] <= cr_cmd.wdata | irq_word;
      end else begin
        cr_q[`CR_ISR] <= isr | irq_word;
      end
    end
  end

  // Control read latch
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      crdata_q <= '0;
    end else if (rd_adv) begin
      crdata_q <= crdata_d;
    end
  end

  assign crdata = crdata_q;

  // Status view, straight from storage
  assign status.kmode           = (cr_q[`CR_PSR] != '0);
  assign status.interrupt_state = imr[`IMR_EN_BIT] ? (isr & imr) : '0;
  assign status.pid             = cr_q[`CR_PID];
  assign status.epc_out         = cr_q[`CR_EPC];
  assign status.efg_out         = cr_q[`CR_EFG];
  // r1 lives in the GPR file, merged in at the top level
  assign status.ret_val         = '0;

endmodule

/* verilog/regstate_top.sv */
`include "regstate_cfg.svh"

module regstate_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      clk_en,
  input  logic                      stall,
  input  regstate_pkg::rd_req_t     rd,
  input  regstate_pkg::wb_req_t     wb,
  input  regstate_pkg::exc_evt_t    evt,
  input  logic [`REGSTATE_IRQS-1:0] interrupts,
  output regstate_pkg::rd_data_t    rd_out,
  output regstate_pkg::status_t     status
);

  regstate_pkg::gpr_cmd_t    gpr_wr0;
  regstate_pkg::gpr_cmd_t    gpr_wr1;
  regstate_pkg::gpr_rd_sel_t gpr_rd0_sel;
  regstate_pkg::gpr_rd_sel_t gpr_rd1_sel;
  regstate_pkg::cr_cmd_t     cr_cmd;
  regstate_pkg::word_t       rdata0;
  regstate_pkg::word_t       rdata1;
  regstate_pkg::word_t       crdata;
  regstate_pkg::word_t       ret_val;
  regstate_pkg::status_t     cr_status;

  // Command resolution, kmode fed back from the control registers
  wb_exc_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .clk_en      (clk_en),
    .stall       (stall),
    .rd          (rd),
    .wb          (wb),
    .evt         (evt),
    .kmode       (cr_status.kmode),
    .gpr_wr0     (gpr_wr0),
    .gpr_wr1     (gpr_wr1),
    .gpr_rd0_sel (gpr_rd0_sel),
    .gpr_rd1_sel (gpr_rd1_sel),
    .cr_cmd      (cr_cmd)
  );

  gpr_file u_gpr (
    .clk         (clk),
    .arst_n      (arst_n),
    .clk_en      (clk_en),
    .stall       (stall),
    .gpr_wr0     (gpr_wr0),
    .gpr_wr1     (gpr_wr1),
    .raddr0      (rd.raddr0),
    .raddr1      (rd.raddr1),
    .gpr_rd0_sel (gpr_rd0_sel),
    .gpr_rd1_sel (gpr_rd1_sel),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .ret_val     (ret_val)
  );

  ctrl_reg_file u_cr (
    .clk        (clk),
    .arst_n     (arst_n),
    .clk_en     (clk_en),
    .stall      (stall),
    .cr_cmd     (cr_cmd),
    .craddr     (rd.craddr),
    .flags_live (evt.flags_live),
    .interrupts (interrupts),
    .crdata     (crdata),
    .status     (cr_status)
  );

  assign rd_out = '{rdata0: rdata0, rdata1: rdata1, crdata: crdata};

  // Control status plus r1 from the GPR file
  assign status = '{kmode:           cr_status.kmode,
                    interrupt_state: cr_status.interrupt_state,
                    pid:             cr_status.pid,
                    epc_out:         cr_status.epc_out,
                    efg_out:         cr_status.efg_out,
                    ret_val:         ret_val};

endmodule

/* sim/regstate_checker.sv */
`include "regstate_cfg.svh"

module regstate_checker (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   clk_en,
  input logic                   stall,
  input regstate_pkg::rd_req_t  rd,
  input regstate_pkg::wb_req_t  wb,
  input regstate_pkg::exc_evt_t evt,
  input regstate_pkg::rd_data_t rd_out,
  input regstate_pkg::status_t  status
);
  timeunit 1ns;
  timeprecision 100ps;

  logic go;
  logic psr_wr;
  logic cr_wr;
  logic evt_go;

  // Qualified events as the DUT sees them at an edge
  assign go     = clk_en && !stall;
  assign cr_wr  = clk_en && wb.cwen;
  assign psr_wr = cr_wr && (wb.cwaddr == `REGSTATE_IDXW'(`CR_PSR));
  assign evt_go = go && (evt.exc || evt.rfe);

  // r0 is hardwired to zero on both read ports
  a_r0_port0: assert property (@(posedge clk) disable iff (!arst_n)
    (go && rd.raddr0 == '0) |=> (rd_out.rdata0 == '0))
    else $error("Mismatch at %0t: r0 read on port 0 is not zero", $time);
  a_r0_port1: assert property (@(posedge clk) disable iff (!arst_n)
    (go && rd.raddr1 == '0) |=> (rd_out.rdata1 == '0))
    else $error("Mismatch at %0t: r0 read on port 1 is not zero", $time);

  // Read latches freeze under back-pressure
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    stall |=> $stable(rd_out))
    else $error("Mismatch at %0t: read outputs moved while stalled", $time);

  // Disabled cycle, only the ISR may move
  a_clk_en_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !clk_en |=> ($stable(rd_out) && $stable(status.kmode) && $stable(status.pid) &&
                 $stable(status.epc_out) && $stable(status.efg_out) &&
                 $stable(status.ret_val)))
    else $error("Mismatch at %0t: state changed with clk_en low", $time);

  // kmode tracks the nesting level
  a_exc_kmode: assert property (@(posedge clk) disable iff (!arst_n)
    (go && evt.exc) |=> status.kmode)
    else $error("Mismatch at %0t: kmode low after exception entry", $time);
  a_kmode_steady: assert property (@(posedge clk) disable iff (!arst_n)
    (!psr_wr && !evt_go) |=> $stable(status.kmode))
    else $error("Mismatch at %0t: kmode changed without PSR update", $time);

  // Interrupt entry closes the mask gate
  a_irq_mask: assert property (@(posedge clk) disable iff (!arst_n)
    (go && evt.exc && evt.irq) |=> (status.interrupt_state == '0))
    else $error("Mismatch at %0t: interrupts visible after irq entry", $time);

  // Pending bits are sticky while nothing rewrites ISR or IMR
  a_isr_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    (!cr_wr && !evt_go) |=> ((status.interrupt_state & $past(status.interrupt_state)) ==
                             $past(status.interrupt_state)))
    else $error("Mismatch at %0t: pending interrupt bit cleared", $time);

endmodule

bind regstate_top regstate_checker u_checker (
  .clk    (clk),
  .arst_n (arst_n),
  .clk_en (clk_en),
  .stall  (stall),
  .rd     (rd),
  .wb     (wb),
  .evt    (evt),
  .rd_out (rd_out),
  .status (status)
);

/* sim/regstate_tb.sv */
`include "regstate_cfg.svh"

module regstate_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 3;
  localparam int ROUND_CYCLES = 120;
  localparam int USER_CYCLES  = 80;
  localparam int MIXED_CYCLES = 200;
  localparam int TIMEOUT_CYCLES =
    4 * (RESET_CYCLES + ROUND_CYCLES + 1 + USER_CYCLES + MIXED_CYCLES + 1);

  localparam regstate_pkg::reg_idx_t IDX_PSR   = `CR_PSR;
  localparam regstate_pkg::reg_idx_t IDX_PID   = `CR_PID;
  localparam regstate_pkg::reg_idx_t IDX_ISR   = `CR_ISR;
  localparam regstate_pkg::reg_idx_t IDX_IMR   = `CR_IMR;
  localparam regstate_pkg::reg_idx_t IDX_EPC   = `CR_EPC;
  localparam regstate_pkg::reg_idx_t IDX_FLG   = `CR_FLG;
  localparam regstate_pkg::reg_idx_t IDX_EFG   = `CR_EFG;
  localparam regstate_pkg::reg_idx_t IDX_TLBA  = `CR_TLBA;
  localparam regstate_pkg::reg_idx_t IDX_CID   = `CR_CID;
  localparam regstate_pkg::reg_idx_t IDX_ALIAS = 31;

  logic                      clk;
  logic                      arst_n;
  logic                      clk_en;
  logic                      stall;
  regstate_pkg::rd_req_t     rd;
  regstate_pkg::wb_req_t     wb;
  regstate_pkg::exc_evt_t    evt;
  logic [`REGSTATE_IRQS-1:0] interrupts;
  regstate_pkg::rd_data_t    rd_out;
  regstate_pkg::status_t     status;

  // Shadow copy of the architectural state
  regstate_pkg::word_t m_gpr [0:`REGSTATE_NREGS-1];
  regstate_pkg::word_t m_cr  [0:`REGSTATE_NREGS-1];
  regstate_pkg::word_t m_ksp;
  regstate_pkg::word_t m_rd0;
  regstate_pkg::word_t m_rd1;
  regstate_pkg::word_t m_crd;
  logic                last_go;
  logic [31:0]         lcg_state;
  int                  cycle_count;

  regstate_top dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .clk_en     (clk_en),
    .stall      (stall),
    .rd         (rd),
    .wb         (wb),
    .evt        (evt),
    .interrupts (interrupts),
    .rd_out     (rd_out),
    .status     (status)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Halves swapped so the low fields come from the better high bits
  task automatic rand32(output logic [31:0] v);
    lcg_state = lcg_step(lcg_state);
    v = {lcg_state[15:0], lcg_state[31:16]};
  endtask

  // r31 is the KSP in kernel mode unless the access opts out
  function automatic regstate_pkg::word_t read_gpr(input regstate_pkg::reg_idx_t a,
                                                   input logic na, input logic km);
    if (a == '0) begin
      return '0;
    end
    if (km && !na && a == IDX_ALIAS) begin
      return m_ksp;
    end
    return m_gpr[a];
  endfunction

  function automatic regstate_pkg::word_t read_cr(input regstate_pkg::reg_idx_t a);
    if (a == IDX_PSR || a == IDX_CID) begin
      return '0;
    end
    if (a == IDX_FLG) begin
      return `REGSTATE_XLEN'(evt.flags_live);
    end
    return m_cr[a];
  endfunction

  task automatic reset_model;
    for (int i = 0; i < `REGSTATE_NREGS; i++) begin
      m_gpr[i] = '0;
      m_cr[i]  = '0;
    end
    m_cr[IDX_PSR] = 32'd1;
    m_ksp = '0;
    m_rd0 = '0;
    m_rd1 = '0;
    m_crd = '0;
  endtask

  task automatic report_mismatch(input string what);
    $display("Mismatch at %0t: %s", $time, what);
    $display("Test failed");
    $fatal(1);
  endtask

  // Advance the shadow by one edge using the inputs held across it
  task automatic apply_edge;
    regstate_pkg::word_t    n_gpr [0:`REGSTATE_NREGS-1];
    regstate_pkg::word_t    n_cr  [0:`REGSTATE_NREGS-1];
    regstate_pkg::word_t    n_ksp;
    regstate_pkg::word_t    irq_word;
    regstate_pkg::wb_port_t port;
    logic                   km;
    int                     p;
    n_gpr    = m_gpr;
    n_cr     = m_cr;
    n_ksp    = m_ksp;
    km       = (m_cr[IDX_PSR] != '0);
    irq_word = `REGSTATE_XLEN'(interrupts);
    last_go  = clk_en && !stall;
    // Reads see the state from before the edge
    if (last_go) begin
      m_rd0 = read_gpr(rd.raddr0, rd.read_no_alias, km);
      m_rd1 = read_gpr(rd.raddr1, rd.read_no_alias, km);
      m_crd = read_cr(rd.craddr);
    end
    // Port 1 after port 0, so it wins a collision
    for (p = 0; p < 2; p++) begin
      port = (p == 0) ? wb.port0 : wb.port1;
      if (clk_en && port.wen && port.waddr != '0) begin
        if (km && !port.no_alias && port.waddr == IDX_ALIAS) begin
          n_ksp = port.wdata;
        end else begin
          n_gpr[port.waddr] = port.wdata;
        end
      end
    end
    // CID is read only
    if (clk_en && wb.cwen && wb.cwaddr != IDX_ISR && wb.cwaddr != IDX_CID) begin
      n_cr[wb.cwaddr] = wb.cwdata;
    end
    // Exception first, an event overrides a plain write
    if (last_go && evt.exc) begin
      n_cr[IDX_PSR] = m_cr[IDX_PSR] + 32'd1;
      n_cr[IDX_EPC] = evt.epc;
      n_cr[IDX_EFG] = evt.efg;
      if (evt.tlb_exc) begin
        n_cr[IDX_TLBA] = evt.tlb_addr;
      end
      if (evt.irq) begin
        n_cr[IDX_IMR][`IMR_EN_BIT] = 1'b0;
      end
    end else if (last_go && evt.rfe) begin
      n_cr[IDX_PSR] = m_cr[IDX_PSR] - 32'd1;
      if (evt.rfi) begin
        n_cr[IDX_IMR][`IMR_EN_BIT] = 1'b1;
      end
    end
    // ISR merges the lines on every edge
    if (clk_en && wb.cwen && wb.cwaddr == IDX_ISR) begin
      n_cr[IDX_ISR] = wb.cwdata | irq_word;
    end else begin
      n_cr[IDX_ISR] = m_cr[IDX_ISR] | irq_word;
    end
    m_gpr = n_gpr;
    m_cr  = n_cr;
    m_ksp = n_ksp;
  endtask

  task automatic compare_outputs;
    regstate_pkg::rd_data_t exp_rd;
    regstate_pkg::status_t  exp_st;
    exp_rd.rdata0          = m_rd0;
    exp_rd.rdata1          = m_rd1;
    exp_rd.crdata          = m_crd;
    exp_st.kmode           = (m_cr[IDX_PSR] != '0);
    exp_st.interrupt_state = m_cr[IDX_IMR][`IMR_EN_BIT] ? (m_cr[IDX_ISR] & m_cr[IDX_IMR]) : '0;
    exp_st.pid             = m_cr[IDX_PID];
    exp_st.epc_out         = m_cr[IDX_EPC];
    exp_st.efg_out         = m_cr[IDX_EFG];
    exp_st.ret_val         = m_gpr[1];
    assert (rd_out === exp_rd)
      else report_mismatch($sformatf("rd_out %h, expected %h", rd_out, exp_rd));
    assert (status === exp_st)
      else report_mismatch($sformatf("status %h, expected %h", status, exp_st));
  endtask

  // Mixed mode adds back-pressure, control writes, events and interrupt pulses
  task automatic pick_inputs(input logic mixed);
    logic [31:0] r;
    logic        hold;
    // An event seen on a blocked edge stays presented until it retires
    hold = (evt.exc || evt.rfe) && !last_go;
    rand32(r);
    wb.port0.wen      = r[0];
    wb.port0.waddr    = r[5:1];
    wb.port0.no_alias = r[6];
    wb.port1.wen      = r[7];
    wb.port1.waddr    = r[13] ? r[5:1] : r[12:8];
    wb.port1.no_alias = r[14];
    rand32(r);
    wb.port0.wdata = r;
    rand32(r);
    wb.port1.wdata = r;
    rand32(r);
    rd.raddr0        = r[4:0];
    rd.raddr1        = r[9:5];
    rd.read_no_alias = r[10];
    rd.craddr        = {1'b0, r[14:11]};
    clk_en     = 1'b1;
    stall      = 1'b0;
    interrupts = '0;
    wb.cwen    = 1'b0;
    wb.cwaddr  = '0;
    wb.cwdata  = '0;
    if (!hold) begin
      evt = '0;
      rand32(r);
      evt.flags_live = r[3:0];
    end
    if (mixed) begin
      rand32(r);
      clk_en     = (r[1:0] != 2'b00);
      stall      = (r[3:2] == 2'b00);
      interrupts = (r[6:4] == 3'b000) ? (16'h1 << r[10:7]) : '0;
      wb.cwen    = r[11];
      wb.cwaddr  = {1'b0, r[15:12]};
      rand32(r);
      wb.cwdata  = r;
      if (!hold) begin
        rand32(r);
        evt.exc     = (r[6:4] == 3'b000);
        // No return below level zero
        evt.rfe     = (r[9:7] == 3'b000) && (m_cr[IDX_PSR] != '0);
        evt.tlb_exc = r[10];
        evt.irq     = r[11];
        evt.rfi     = r[12];
        rand32(r);
        evt.epc = r;
        rand32(r);
        evt.efg = r;
        rand32(r);
        evt.tlb_addr = r;
      end
      // Keep nesting small and untouched while an event is pending
      if (wb.cwaddr == IDX_PSR) begin
        wb.cwdata = {30'b0, wb.cwdata[1:0]};
        if (evt.exc || evt.rfe) begin
          wb.cwen = 1'b0;
        end
      end
    end
  endtask

  task automatic advance;
    @(posedge clk);
    #2;
    apply_edge();
    compare_outputs();
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    clk_en      = 1'b1;
    stall       = 1'b0;
    rd          = '0;
    wb          = '0;
    evt         = '0;
    interrupts  = '0;
    lcg_state   = 32'ha52a;
    cycle_count = 0;
    last_go     = 1'b1;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    compare_outputs();
    // Kernel mode traffic, r31 lands in the KSP
    repeat (ROUND_CYCLES) begin
      pick_inputs(1'b0);
      advance();
    end
    // Nesting level to zero for user mode
    wb        = '0;
    evt       = '0;
    wb.cwen   = 1'b1;
    wb.cwaddr = IDX_PSR;
    advance();
    repeat (USER_CYCLES) begin
      pick_inputs(1'b0);
      advance();
    end
    repeat (MIXED_CYCLES) begin
      pick_inputs(1'b1);
      advance();
    end
    // One clean edge retires any parked event
    pick_inputs(1'b0);
    advance();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* regstate.f */
+incdir+verilog
verilog/regstate_pkg.sv
verilog/wb_exc_ctrl.sv
verilog/gpr_file.sv
verilog/ctrl_reg_file.sv
verilog/regstate_top.sv
sim/regstate_checker.sv
sim/regstate_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register state testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module regstate_tb -f regstate.f -Mdir obj_dir -o regstate_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/regstate_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
